/* branchRsPkg.sv */
package branchRsPkg;

    localparam int TagWidth = 8;
    localparam int XlenWidth = 32;
    localparam int InstNumWidth = 32;
    localparam int Funct3Width = 3;

    // broadcast order: alu, mul, div, load
    localparam int NumWakeup = 4;

    typedef logic [TagWidth-1:0] tagT;
    typedef tagT [NumWakeup-1:0] wakeTagsT;

    // one stored branch/jump op
    typedef struct packed {
        logic [InstNumWidth-1:0] instNum;
        logic [XlenWidth-1:0] pc;
        logic [XlenWidth-1:0] imm;
        logic [Funct3Width-1:0] funct3;
        tagT rd;
        tagT src1;
        tagT src2;
        logic branch;
        logic jump;
        logic predTaken;
        logic btbHit;
    } brOpT;

    // true when any valid bus carries tag
    function automatic logic tagHit(
        input tagT tag,
        input wakeTagsT busTags,
        input logic [NumWakeup-1:0] busValids
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NumWakeup; i++) begin
            if (busValids[i] && (busTags[i] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

/* wakeupIf.sv */
interface wakeupIf import branchRsPkg::*; ();

    wakeTagsT tags;                 // indexed by bus
    logic [NumWakeup-1:0] valids;

    // top side, maps the result buses in
    modport producer (
        output tags,
        output valids
    );

    // reservation station side
    modport consumer (
        input tags,
        input valids
    );

endinterface

/* branchRsQueue.sv */
module branchRsQueue import branchRsPkg::*; #(
    parameter int Depth = 16
) (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic dispatch,
    input brOpT dispatchOp,
    input logic [1:0] srcValid,
    wakeupIf.consumer wake,
    input logic pop,
    output brOpT headOp,
    output logic headReady
);

    localparam int PtrWidth = $clog2(Depth);

    brOpT entries [Depth];
    logic [Depth-1:0] ready1;
    logic [Depth-1:0] ready2;
    logic [Depth-1:0] occupied;
    logic [PtrWidth-1:0] head;
    logic [PtrWidth-1:0] tail;
    logic dispReady1;
    logic dispReady2;

    // operand ready at dispatch: rename says so, or its tag is on a bus right now
    assign dispReady1 = srcValid[0] | tagHit(dispatchOp.src1, wake.tags, wake.valids);
    assign dispReady2 = srcValid[1] | tagHit(dispatchOp.src2, wake.tags, wake.valids);

    assign headOp = entries[head];
    assign headReady = occupied[head] & ready1[head] & ready2[head];

    // payload store
    always_ff @(posedge clk) begin
        if (dispatch && !flush) begin
            entries[tail] <= dispatchOp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            occupied <= '0;
            ready1 <= '0;
            ready2 <= '0;
        end else begin
            // wakeup of waiting operands
            for (int i = 0; i < Depth; i++) begin
                if (tagHit(entries[i].src1, wake.tags, wake.valids)) begin
                    ready1[i] <= 1'b1;
                end
                if (tagHit(entries[i].src2, wake.tags, wake.valids)) begin
                    ready2[i] <= 1'b1;
                end
            end

            if (dispatch) begin
                occupied[tail] <= 1'b1;
                ready1[tail] <= dispReady1;    // overrides stale wakeup
                ready2[tail] <= dispReady2;
                tail <= tail + 1'b1;           // depth is a power of two
            end

            // issue takes the head
            if (pop) begin
                occupied[head] <= 1'b0;
                ready1[head] <= 1'b0;
                ready2[head] <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

endmodule

/* branchRsIssue.sv */
module branchRsIssue import branchRsPkg::*; (
    input logic clk,
    input logic reset,
    input logic flush,
    input brOpT headOp,
    input logic headReady,
    output logic pop,
    output logic issueBranch,
    output logic issueJump,
    output logic issueHit,
    output logic issueTaken,
    output tagT issueRd,
    output logic [InstNumWidth-1:0] issueInstNum,
    output logic [Funct3Width-1:0] issueFunct3,
    output logic [XlenWidth-1:0] issueImm,
    output logic [XlenWidth-1:0] issuePc,
    output tagT issueSrc1,
    output tagT issueSrc2
);

    // in order, no back-pressure: a ready head always goes
    assign pop = headReady;

    always_ff @(posedge clk) begin
        if (reset || flush || !headReady) begin
            issueBranch <= 1'b0;
            issueJump <= 1'b0;
            issueHit <= 1'b0;
            issueTaken <= 1'b0;
            issueRd <= '0;
            issueInstNum <= '0;
            issueFunct3 <= '0;
            issueImm <= '0;
            issuePc <= '0;
            issueSrc1 <= '0;
            issueSrc2 <= '0;
        end else begin
            issueBranch <= headOp.branch;
            issueJump <= headOp.jump;
            issueHit <= headOp.btbHit;
            issueTaken <= headOp.predTaken;
            issueRd <= headOp.rd;
            issueInstNum <= headOp.instNum;
            issueFunct3 <= headOp.funct3;
            issueImm <= headOp.imm;
            issuePc <= headOp.pc;
            issueSrc1 <= headOp.src1;
            issueSrc2 <= headOp.src2;
        end
    end

endmodule

/* branchRsTop.sv */
module branchRsTop import branchRsPkg::*; #(
    parameter int Depth = 16
) (
    input logic clk,
    input logic reset,
    input logic dispatch,
    input logic mispredict,

    input logic [InstNumWidth-1:0] instNum,
    input logic [XlenWidth-1:0] pc,
    input tagT rd,
    input logic jump,
    input logic branch,
    input logic [Funct3Width-1:0] funct3,
    input logic [XlenWidth-1:0] imm,
    input tagT src1,
    input tagT src2,
    input logic [1:0] srcValid,
    input logic predTaken,
    input logic btbHit,

    input tagT aluTag,
    input logic aluValid,
    input tagT mulTag,
    input logic mulValid,
    input tagT divTag,
    input logic divValid,
    input tagT loadTag,
    input logic loadValid,

    output logic issueBranch,
    output logic issueJump,
    output logic issueHit,
    output logic issueTaken,
    output tagT issueRd,
    output logic [InstNumWidth-1:0] issueInstNum,
    output logic [Funct3Width-1:0] issueFunct3,
    output logic [XlenWidth-1:0] issueImm,
    output logic [XlenWidth-1:0] issuePc,
    output tagT issueSrc1,
    output tagT issueSrc2
);

    brOpT dispatchOp;
    brOpT headOp;
    logic headReady;
    logic pop;

    wakeupIf wakeBus ();

    assign dispatchOp.instNum = instNum;
    assign dispatchOp.pc = pc;
    assign dispatchOp.imm = imm;
    assign dispatchOp.funct3 = funct3;
    assign dispatchOp.rd = rd;
    assign dispatchOp.src1 = src1;
    assign dispatchOp.src2 = src2;
    assign dispatchOp.branch = branch;
    assign dispatchOp.jump = jump;
    assign dispatchOp.predTaken = predTaken;
    assign dispatchOp.btbHit = btbHit;

    // bus order alu, mul, div, load
    assign wakeBus.tags[0] = aluTag;
    assign wakeBus.tags[1] = mulTag;
    assign wakeBus.tags[2] = divTag;
    assign wakeBus.tags[3] = loadTag;
    assign wakeBus.valids = {loadValid, divValid, mulValid, aluValid};

    branchRsQueue #(
        .Depth(Depth)
    ) u_queue (
        .clk(clk),
        .reset(reset),
        .flush(mispredict),
        .dispatch(dispatch),
        .dispatchOp(dispatchOp),
        .srcValid(srcValid),
        .wake(wakeBus.consumer),
        .pop(pop),
        .headOp(headOp),
        .headReady(headReady)
    );

    branchRsIssue u_issue (
        .clk(clk),
        .reset(reset),
        .flush(mispredict),
        .headOp(headOp),
        .headReady(headReady),
        .pop(pop),
        .issueBranch(issueBranch),
        .issueJump(issueJump),
        .issueHit(issueHit),
        .issueTaken(issueTaken),
        .issueRd(issueRd),
        .issueInstNum(issueInstNum),
        .issueFunct3(issueFunct3),
        .issueImm(issueImm),
        .issuePc(issuePc),
        .issueSrc1(issueSrc1),
        .issueSrc2(issueSrc2)
    );

endmodule

/* branchRsTbTable.svh */
// id kind src1 src2 srcValid bus busTag busValid mispredict expId expKind
// expected issue shows one full cycle after the row's edge
rowT stimRows [TableLen] = '{
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    // ready ops stream out in order
    '{8'd1, 2'b10, 8'h01, 8'h02, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd1, 2'b10},
    '{8'd2, 2'b01, 8'h03, 8'h04, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd2, 2'b01},
    '{8'd3, 2'b10, 8'h05, 8'h06, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd3, 2'b10},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    // blocked head, alu wakeup
    '{8'd4, 2'b10, 8'h40, 8'h07, 2'b10, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd5, 2'b01, 8'h08, 8'h09, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h40, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd1, 8'h41, 1'b1, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h40, 1'b1, 1'b0, 8'd4, 2'b10},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd5, 2'b01},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    // mul wakeup on src2
    '{8'd6, 2'b10, 8'h0a, 8'h52, 2'b01, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd7, 2'b10, 8'h0b, 8'h0c, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd1, 8'h52, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd1, 8'h52, 1'b1, 1'b0, 8'd6, 2'b10},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd7, 2'b10},
    // div, both sources waiting
    '{8'd8, 2'b01, 8'h63, 8'h64, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd9, 2'b10, 8'h0d, 8'h0e, 2'b11, 2'd2, 8'h63, 1'b1, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd2, 8'h64, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd2, 8'h64, 1'b1, 1'b0, 8'd8, 2'b01},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd9, 2'b10},
    // load wakeup
    '{8'd10, 2'b10, 8'h75, 8'h0f, 2'b10, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd11, 2'b01, 8'h10, 8'h11, 2'b11, 2'd3, 8'h75, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd3, 8'h75, 1'b1, 1'b0, 8'd10, 2'b10},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd11, 2'b01},
    // tag on a bus in the dispatch cycle
    '{8'd12, 2'b10, 8'h86, 8'h12, 2'b10, 2'd0, 8'h86, 1'b1, 1'b0, 8'd12, 2'b10},
    '{8'd13, 2'b01, 8'h97, 8'h97, 2'b00, 2'd3, 8'h97, 1'b1, 1'b0, 8'd13, 2'b01},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    // flush with waiting ops, late wakeups must not revive them
    '{8'd14, 2'b10, 8'ha1, 8'h13, 2'b10, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd15, 2'b01, 8'h14, 8'ha2, 2'b01, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b1, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'ha1, 1'b1, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd1, 8'ha2, 1'b1, 1'b0, 8'd0, 2'b00},
    '{8'd16, 2'b10, 8'h15, 8'h16, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd16, 2'b10},
    '{8'd17, 2'b01, 8'hb3, 8'h17, 2'b10, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd3, 8'hb3, 1'b1, 1'b0, 8'd17, 2'b01},
    // flush on the edge a ready head would issue
    '{8'd18, 2'b10, 8'h18, 8'h19, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b1, 8'd0, 2'b00},
    '{8'd19, 2'b01, 8'h1a, 8'h1b, 2'b11, 2'd0, 8'h00, 1'b0, 1'b0, 8'd19, 2'b01},
    '{8'd0, 2'b00, 8'h00, 8'h00, 2'b00, 2'd0, 8'h00, 1'b0, 1'b0, 8'd0, 2'b00}
};

/* branchRsTb.sv */
module branchRsTb import branchRsPkg::*; ();

    localparam int Depth = 16;
    localparam int ResetCycles = 4;
    localparam int IssueDelay = 2;          // rows between a drive and its issue check
    localparam int TableLen = 42;
    localparam int RowIdxWidth = $clog2(TableLen);
    localparam int TimeoutMargin = 20;
    localparam int TimeoutCycles = TableLen + TimeoutMargin;
    localparam logic [31:0] LcgSeed = 32'hec9d4929;
    localparam logic [31:0] LcgMul = 32'd1664525;
    localparam logic [31:0] LcgInc = 32'd1013904223;

    typedef struct packed {
        logic [7:0] id;                     // 0 means no dispatch
        logic [1:0] kind;                   // {branch, jump}
        tagT src1;
        tagT src2;
        logic [1:0] srcValid;
        logic [1:0] bus;                    // 0 alu, 1 mul, 2 div, 3 load
        tagT busTag;
        logic busValid;
        logic mispredict;
        logic [7:0] expId;                  // 0 means nothing issues
        logic [1:0] expKind;
    } rowT;

    logic clk;
    logic reset;
    logic dispatch;
    logic mispredict;
    logic [InstNumWidth-1:0] instNum;
    logic [XlenWidth-1:0] pc;
    tagT rd;
    logic jump;
    logic branch;
    logic [Funct3Width-1:0] funct3;
    logic [XlenWidth-1:0] imm;
    tagT src1;
    tagT src2;
    logic [1:0] srcValid;
    logic predTaken;
    logic btbHit;
    tagT aluTag;
    logic aluValid;
    tagT mulTag;
    logic mulValid;
    tagT divTag;
    logic divValid;
    tagT loadTag;
    logic loadValid;
    logic issueBranch;
    logic issueJump;
    logic issueHit;
    logic issueTaken;
    tagT issueRd;
    logic [InstNumWidth-1:0] issueInstNum;
    logic [Funct3Width-1:0] issueFunct3;
    logic [XlenWidth-1:0] issueImm;
    logic [XlenWidth-1:0] issuePc;
    tagT issueSrc1;
    tagT issueSrc2;

    `include "branchRsTbTable.svh"

    brOpT sent [256];                       // dispatched ops by instNum
    logic [31:0] randState;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    branchRsTop #(
        .Depth(Depth)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .mispredict(mispredict),
        .instNum(instNum),
        .pc(pc),
        .rd(rd),
        .jump(jump),
        .branch(branch),
        .funct3(funct3),
        .imm(imm),
        .src1(src1),
        .src2(src2),
        .srcValid(srcValid),
        .predTaken(predTaken),
        .btbHit(btbHit),
        .aluTag(aluTag),
        .aluValid(aluValid),
        .mulTag(mulTag),
        .mulValid(mulValid),
        .divTag(divTag),
        .divValid(divValid),
        .loadTag(loadTag),
        .loadValid(loadValid),
        .issueBranch(issueBranch),
        .issueJump(issueJump),
        .issueHit(issueHit),
        .issueTaken(issueTaken),
        .issueRd(issueRd),
        .issueInstNum(issueInstNum),
        .issueFunct3(issueFunct3),
        .issueImm(issueImm),
        .issuePc(issuePc),
        .issueSrc1(issueSrc1),
        .issueSrc2(issueSrc2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            errorCount++;
            $display("timeout: stimulus did not complete within %0d cycles", TimeoutCycles);
            $display("%0d checks, %0d errors", checkCount, errorCount);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * LcgMul + LcgInc;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] actual,
            input logic [63:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic checkIdle();
        compareValue("issueBranch", 64'(issueBranch), 64'd0);
        compareValue("issueJump", 64'(issueJump), 64'd0);
        compareValue("issueHit", 64'(issueHit), 64'd0);
        compareValue("issueTaken", 64'(issueTaken), 64'd0);
        compareValue("issueRd", 64'(issueRd), 64'd0);
        compareValue("issueInstNum", 64'(issueInstNum), 64'd0);
        compareValue("issueFunct3", 64'(issueFunct3), 64'd0);
        compareValue("issueImm", 64'(issueImm), 64'd0);
        compareValue("issuePc", 64'(issuePc), 64'd0);
        compareValue("issueSrc1", 64'(issueSrc1), 64'd0);
        compareValue("issueSrc2", 64'(issueSrc2), 64'd0);
    endtask

    task automatic checkIssue(input logic [7:0] id, input logic [1:0] kind);
        brOpT op;
        op = sent[id];
        compareValue("issueInstNum", 64'(issueInstNum), 64'(id));
        compareValue("issueBranch", 64'(issueBranch), 64'(kind[1]));
        compareValue("issueJump", 64'(issueJump), 64'(kind[0]));
        compareValue("issuePc", 64'(issuePc), 64'(op.pc));
        compareValue("issueImm", 64'(issueImm), 64'(op.imm));
        compareValue("issueRd", 64'(issueRd), 64'(op.rd));
        compareValue("issueFunct3", 64'(issueFunct3), 64'(op.funct3));
        compareValue("issueSrc1", 64'(issueSrc1), 64'(op.src1));
        compareValue("issueSrc2", 64'(issueSrc2), 64'(op.src2));
        compareValue("issueTaken", 64'(issueTaken), 64'(op.predTaken));
        compareValue("issueHit", 64'(issueHit), 64'(op.btbHit));
    endtask

    task automatic checkRow(input rowT row);
        if (row.expId == 8'd0) begin
            checkIdle();
        end else begin
            checkIssue(row.expId, row.expKind);
        end
    endtask

    task automatic driveRow(input rowT row);
        logic [31:0] busRand;
        brOpT op;
        // idle buses carry junk tags with valid low
        randState = lcgNext(randState);
        busRand = randState;
        aluTag = busRand[31:24];
        mulTag = busRand[23:16];
        divTag = busRand[15:8];
        loadTag = busRand[7:0];
        aluValid = 1'b0;
        mulValid = 1'b0;
        divValid = 1'b0;
        loadValid = 1'b0;
        case (row.bus)
            2'd0: begin
                aluTag = row.busTag;
                aluValid = row.busValid;
            end
            2'd1: begin
                mulTag = row.busTag;
                mulValid = row.busValid;
            end
            2'd2: begin
                divTag = row.busTag;
                divValid = row.busValid;
            end
            default: begin
                loadTag = row.busTag;
                loadValid = row.busValid;
            end
        endcase
        mispredict = row.mispredict;
        if (row.id != 8'd0) begin
            op.instNum = 32'(row.id);
            randState = lcgNext(randState);
            op.pc = {randState[31:2], 2'b00};
            randState = lcgNext(randState);
            op.imm = randState;
            randState = lcgNext(randState);
            op.rd = randState[31:24];
            op.funct3 = randState[18:16];
            op.predTaken = randState[20];
            op.btbHit = randState[21];
            op.src1 = row.src1;
            op.src2 = row.src2;
            op.branch = row.kind[1];
            op.jump = row.kind[0];
            sent[row.id] = op;
            dispatch = 1'b1;
            instNum = op.instNum;
            pc = op.pc;
            imm = op.imm;
            rd = op.rd;
            funct3 = op.funct3;
            predTaken = op.predTaken;
            btbHit = op.btbHit;
            src1 = op.src1;
            src2 = op.src2;
            branch = op.branch;
            jump = op.jump;
            srcValid = row.srcValid;
        end else begin
            dispatch = 1'b0;
            srcValid = 2'b00;
        end
    endtask

    initial begin
        reset = 1'b1;
        dispatch = 1'b0;
        mispredict = 1'b0;
        instNum = '0;
        pc = '0;
        rd = '0;
        jump = 1'b0;
        branch = 1'b0;
        funct3 = '0;
        imm = '0;
        src1 = '0;
        src2 = '0;
        srcValid = 2'b00;
        predTaken = 1'b0;
        btbHit = 1'b0;
        aluTag = '0;
        aluValid = 1'b0;
        mulTag = '0;
        mulValid = 1'b0;
        divTag = '0;
        divValid = 1'b0;
        loadTag = '0;
        loadValid = 1'b0;
        randState = LcgSeed;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkIdle();                        // nothing issues out of reset
        for (int step = 0; step < TableLen + IssueDelay; step++) begin
            if (step >= IssueDelay) begin
                checkRow(stimRows[RowIdxWidth'(step - IssueDelay)]);
            end
            if (step < TableLen) begin
                driveRow(stimRows[RowIdxWidth'(step)]);
            end else begin
                driveRow('0);
            end
            @(negedge clk);
        end
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* branchRs.f */
+incdir+.
branchRsPkg.sv
wakeupIf.sv
branchRsQueue.sv
branchRsIssue.sv
branchRsTop.sv
branchRsTb.sv

/* Makefile */
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing -j 0
TOP = branchRsTb
FILELIST = branchRs.f
OBJ_DIR = obj_dir
PASS_MSG = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
